/* design/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data path and address width, one machine word
`define LSU_XLEN 32

// Architectural register index width
`define LSU_REG_IDX_W 5

// Data RAM depth in words; only the low word-address bits reach the array
`define LSU_RAM_WORDS 256

`endif

/* design/lsu_pkg.sv */
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_ALU,  // Write the execute value
        OP_LINK  // Write pc+4
    } lsu_op_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD
    } byte_type_e;

    typedef struct packed {
        logic       is_mem;
        logic       is_store;
        logic       is_signed;
        byte_type_e byte_type;
        logic       is_wr_rd;
        logic       is_wr_rd_pc_plus4;
    } mem_ctrl_t;

    typedef struct packed {
        logic                      valid;
        mem_ctrl_t                 ctrl;
        logic [1:0]                byte_en;  // Low two address bits
        logic [`LSU_REG_IDX_W-1:0] rd;
        logic [`LSU_XLEN-1:0]      pc;
        logic [`LSU_XLEN-1:0]      pc_plus4;
        logic [`LSU_XLEN-1:0]      ex_out;
    } mem1_mem2_pass_t;

    typedef struct packed {
        logic                      valid;
        logic [`LSU_REG_IDX_W-1:0] rd;
        logic [`LSU_XLEN-1:0]      pc;
        logic [`LSU_XLEN-1:0]      ex_mem_out;
    } mem2_wb_pass_t;

endpackage

`default_nettype wire

/* design/dcache_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

// A request is taken on the clock edge while req is high; read data follows one cycle later
interface dcache_if;

    logic                   req;
    logic                   we;
    logic [`LSU_XLEN/8-1:0] strb;
    logic [`LSU_XLEN-1:0]   addr;
    logic [`LSU_XLEN-1:0]   wdata;
    logic [`LSU_XLEN-1:0]   rdata;

    modport requester (output req, output we, output strb, output addr, output wdata);

    modport memory (input req, input we, input strb, input addr, input wdata, output rdata);

    modport reader (input rdata);

endinterface

`default_nettype wire

/* design/lsu_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_ctrl (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire lsu_pkg::lsu_op_e          in_op,
    output lsu_pkg::mem_ctrl_t             mem_ctrl,
    input  wire lsu_pkg::mem2_wb_pass_t    pass_in,
    output logic                           wb_valid,
    output logic [`LSU_REG_IDX_W-1:0]      wb_rd,
    output logic [`LSU_XLEN-1:0]           wb_data,
    output logic [`LSU_XLEN-1:0]           wb_pc
);

    import lsu_pkg::*;

    // ############################################################
    // Opcode decode
    // ############################################################

    always_comb begin
        mem_ctrl = '0;
        mem_ctrl.byte_type = WORD;
        case (in_op)
            OP_LB, OP_LBU: begin
                mem_ctrl.is_mem    = 1'b1;
                mem_ctrl.is_signed = (in_op == OP_LB);
                mem_ctrl.byte_type = BYTE;
                mem_ctrl.is_wr_rd  = 1'b1;
            end
            OP_LH, OP_LHU: begin
                mem_ctrl.is_mem    = 1'b1;
                mem_ctrl.is_signed = (in_op == OP_LH);
                mem_ctrl.byte_type = HALF_WORD;
                mem_ctrl.is_wr_rd  = 1'b1;
            end
            OP_LW: begin
                mem_ctrl.is_mem   = 1'b1;
                mem_ctrl.is_wr_rd = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: begin
                mem_ctrl.is_mem   = 1'b1;
                mem_ctrl.is_store = 1'b1;
                if (in_op == OP_SB)      mem_ctrl.byte_type = BYTE;
                else if (in_op == OP_SH) mem_ctrl.byte_type = HALF_WORD;
            end
            OP_ALU:  mem_ctrl.is_wr_rd = 1'b1;
            OP_LINK: begin
                mem_ctrl.is_wr_rd          = 1'b1;
                mem_ctrl.is_wr_rd_pc_plus4 = 1'b1;
            end
            default: mem_ctrl.is_wr_rd = 1'b0;  // Unused codes do nothing
        endcase
    end

    // ############################################################
    // Writeback register
    // ############################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= pass_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pass_in.valid) begin
            wb_rd   <= pass_in.rd;
            wb_data <= pass_in.ex_mem_out;
            wb_pc   <= pass_in.pc;
        end
    end

endmodule

`default_nettype wire

/* design/agu_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module agu_stage (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             flush,
    input  wire                             in_valid,
    input  wire [`LSU_XLEN-1:0]             in_base,
    input  wire [`LSU_XLEN-1:0]             in_imm,
    input  wire [`LSU_XLEN-1:0]             in_store_data,
    input  wire [`LSU_REG_IDX_W-1:0]        in_rd,
    input  wire [`LSU_XLEN-1:0]             in_pc,
    input  wire [`LSU_XLEN-1:0]             in_ex_out,
    input  wire lsu_pkg::mem_ctrl_t         mem_ctrl,
    dcache_if.requester                     dcache,
    output lsu_pkg::mem1_mem2_pass_t        pass_out
);

    import lsu_pkg::*;

    mem1_mem2_pass_t        entry_r;
    mem_ctrl_t              issue_ctrl;
    logic [`LSU_XLEN-1:0]   eff_addr;
    logic [`LSU_XLEN-1:0]   addr_r;
    logic [`LSU_XLEN-1:0]   st_data_r;
    logic [`LSU_XLEN-1:0]   st_wdata;
    logic [`LSU_XLEN/8-1:0] st_strb;

    assign eff_addr = in_base + in_imm;

    // Writes to x0 are dropped like in any RISC-V register file
    always_comb begin
        issue_ctrl = mem_ctrl;
        issue_ctrl.is_wr_rd = mem_ctrl.is_wr_rd & (|in_rd);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_r.valid <= 1'b0;
        end else begin
            entry_r.valid <= in_valid;  // An issue in a flush cycle is kept
            if (in_valid) begin
                entry_r.ctrl     <= issue_ctrl;
                entry_r.byte_en  <= eff_addr[1:0];
                entry_r.rd       <= in_rd;
                entry_r.pc       <= in_pc;
                entry_r.pc_plus4 <= in_pc + `LSU_XLEN'd4;
                entry_r.ex_out   <= in_ex_out;
                addr_r           <= eff_addr;
                st_data_r        <= in_store_data;
            end
        end
    end

    // Store data goes out replicated across lanes, strobes select the live ones
    always_comb begin
        case (entry_r.ctrl.byte_type)
            BYTE: begin
                st_wdata = {4{st_data_r[7:0]}};
                st_strb  = 4'b0001 << entry_r.byte_en;
            end
            HALF_WORD: begin
                st_wdata = {2{st_data_r[15:0]}};
                st_strb  = entry_r.byte_en[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_wdata = st_data_r;
                st_strb  = 4'b1111;
            end
        endcase
    end

    assign dcache.req   = entry_r.valid & entry_r.ctrl.is_mem & ~flush;
    assign dcache.we    = entry_r.ctrl.is_store;
    assign dcache.strb  = entry_r.ctrl.is_store ? st_strb : '0;
    assign dcache.addr  = addr_r;
    assign dcache.wdata = st_wdata;

    always_comb begin
        pass_out = entry_r;
        pass_out.valid = entry_r.valid & ~flush;
    end

endmodule

`default_nettype wire

/* design/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module data_ram (
    input wire          clk,
    input wire          rst_n,
    dcache_if.memory    dcache
);

    logic [`LSU_XLEN-1:0]              mem [`LSU_RAM_WORDS];
    logic [$clog2(`LSU_RAM_WORDS)-1:0] word_idx;

    // Byte offset dropped, upper address bits ignored
    assign word_idx = dcache.addr[$clog2(`LSU_RAM_WORDS)+1:2];

    always_ff @(posedge clk) begin
        if (dcache.req && dcache.we) begin
            for (int i = 0; i < `LSU_XLEN/8; i++) begin
                if (dcache.strb[i]) mem[word_idx][i*8 +: 8] <= dcache.wdata[i*8 +: 8];
            end
        end
    end

    // Read port holds its value until the next read request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dcache.rdata <= '0;
        end else if (dcache.req && !dcache.we) begin
            dcache.rdata <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

/* design/load_align_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module load_align_stage (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              flush,
    input  wire lsu_pkg::mem1_mem2_pass_t    pass_in,
    dcache_if.reader                         dcache,
    output logic                             fwd_valid,
    output logic [`LSU_REG_IDX_W-1:0]        fwd_idx,
    output logic [`LSU_XLEN-1:0]             fwd_data,
    output lsu_pkg::mem2_wb_pass_t           pass_out
);

    import lsu_pkg::*;

    mem1_mem2_pass_t      entry_r;
    logic                 live;
    logic [7:0]           mem_byte;
    logic [15:0]          mem_half;
    logic [`LSU_XLEN-1:0] mem_out;
    logic [`LSU_XLEN-1:0] ex_mem_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_r.valid <= 1'b0;
        end else begin
            entry_r <= pass_in;
        end
    end

    assign live = entry_r.valid & ~flush;

    // ############################################################
    // Forwarding request
    // ############################################################

    // Load data is not ready to forward from here
    assign fwd_valid = live & entry_r.ctrl.is_wr_rd;
    assign fwd_idx   = entry_r.rd;
    assign fwd_data  = entry_r.ctrl.is_wr_rd_pc_plus4 ? entry_r.pc_plus4 : entry_r.ex_out;

    // ############################################################
    // Load extraction and result select
    // ############################################################

    assign mem_byte = dcache.rdata[entry_r.byte_en*8 +: 8];
    assign mem_half = entry_r.byte_en[1] ? dcache.rdata[31:16] : dcache.rdata[15:0];

    always_comb begin
        case (entry_r.ctrl.byte_type)
            BYTE:      mem_out = {{24{entry_r.ctrl.is_signed & mem_byte[7]}}, mem_byte};
            HALF_WORD: mem_out = {{16{entry_r.ctrl.is_signed & mem_half[15]}}, mem_half};
            default:   mem_out = dcache.rdata;
        endcase
    end

    always_comb begin
        if (entry_r.ctrl.is_mem && !entry_r.ctrl.is_store) begin
            ex_mem_out = mem_out;
        end else if (entry_r.ctrl.is_wr_rd_pc_plus4) begin
            ex_mem_out = entry_r.pc_plus4;
        end else begin
            ex_mem_out = entry_r.ex_out;
        end
    end

    assign pass_out.valid      = live & entry_r.ctrl.is_wr_rd;  // Stores never write back
    assign pass_out.rd         = entry_r.rd;
    assign pass_out.pc         = entry_r.pc;
    assign pass_out.ex_mem_out = ex_mem_out;

endmodule

`default_nettype wire

/* design/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         in_valid,
    input  wire lsu_pkg::lsu_op_e       in_op,
    input  wire [`LSU_XLEN-1:0]         in_base,
    input  wire [`LSU_XLEN-1:0]         in_imm,
    input  wire [`LSU_XLEN-1:0]         in_store_data,
    input  wire [`LSU_REG_IDX_W-1:0]    in_rd,
    input  wire [`LSU_XLEN-1:0]         in_pc,
    input  wire [`LSU_XLEN-1:0]         in_ex_out,
    input  wire                         flush,
    output wire                         fwd_valid,
    output wire [`LSU_REG_IDX_W-1:0]    fwd_idx,
    output wire [`LSU_XLEN-1:0]         fwd_data,
    output wire                         wb_valid,
    output wire [`LSU_REG_IDX_W-1:0]    wb_rd,
    output wire [`LSU_XLEN-1:0]         wb_data,
    output wire [`LSU_XLEN-1:0]         wb_pc
);

    import lsu_pkg::*;

    wire mem_ctrl_t       mem_ctrl;
    wire mem1_mem2_pass_t mem1_pass;
    wire mem2_wb_pass_t   mem2_pass;

    dcache_if i_dcache_if ();

    lsu_ctrl i_lsu_ctrl (
        .clk(clk), .rst_n(rst_n), .in_op(in_op), .mem_ctrl(mem_ctrl), .pass_in(mem2_pass),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .wb_pc(wb_pc)
    );

    agu_stage i_agu_stage (
        .clk(clk), .rst_n(rst_n), .flush(flush), .in_valid(in_valid), .in_base(in_base),
        .in_imm(in_imm), .in_store_data(in_store_data), .in_rd(in_rd), .in_pc(in_pc),
        .in_ex_out(in_ex_out), .mem_ctrl(mem_ctrl), .dcache(i_dcache_if.requester),
        .pass_out(mem1_pass)
    );

    data_ram i_data_ram (.clk(clk), .rst_n(rst_n), .dcache(i_dcache_if.memory));

    load_align_stage i_load_align_stage (
        .clk(clk), .rst_n(rst_n), .flush(flush), .pass_in(mem1_pass),
        .dcache(i_dcache_if.reader), .fwd_valid(fwd_valid), .fwd_idx(fwd_idx),
        .fwd_data(fwd_data), .pass_out(mem2_pass)
    );

endmodule

`default_nettype wire

/* test/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_tb;

    import lsu_pkg::*;

    // Init, word, sub-word, partial, stream, forwarding and flush issues
    localparam int ISSUE_COUNT = 16 + 16 + 34 + 16 + 200 + 8 + 10;

    typedef struct {
        int                        cyc;
        logic [`LSU_REG_IDX_W-1:0] rd;
        logic [`LSU_XLEN-1:0]      data;
        logic [`LSU_XLEN-1:0]      pc;
    } expect_t;

    logic                      clk = 1'b0;
    logic                      rst_n, in_valid, flush;
    lsu_op_e                   in_op;
    logic [`LSU_XLEN-1:0]      in_base, in_imm, in_store_data, in_pc, in_ex_out;
    logic [`LSU_REG_IDX_W-1:0] in_rd;
    wire                       fwd_valid, wb_valid;
    wire [`LSU_REG_IDX_W-1:0]  fwd_idx, wb_rd;
    wire [`LSU_XLEN-1:0]       fwd_data, wb_data, wb_pc;

    logic [7:0] ram_model [64];  // Tests stay inside the first 16 words
    expect_t    wb_q [$];
    expect_t    fwd_q [$];
    int         cyc = 0;
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;

    lsu_top i_dut (.*);

    always #5 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // ############################################################
    // Response monitor, sampled on the rising edge
    // ############################################################

    always @(posedge clk) begin
        if (rst_n) begin
            if (wb_q.size() > 0 && wb_q[0].cyc == cyc) begin
                if (!wb_valid) begin
                    errors++;
                    $display("At %0t a writeback to x%0d never arrived", $time, wb_q[0].rd);
                end else begin
                    compare_value("wb_rd", wb_q[0].rd, wb_rd);
                    compare_value("wb_data", wb_q[0].data, wb_data);
                    compare_value("wb_pc", wb_q[0].pc, wb_pc);
                end
                void'(wb_q.pop_front());
            end else if (wb_valid) begin
                errors++;
                $display("At %0t an unexpected writeback to x%0d showed up", $time, wb_rd);
            end
            if (fwd_q.size() > 0 && fwd_q[0].cyc == cyc) begin
                if (!fwd_valid) begin
                    errors++;
                    $display("At %0t a forward of x%0d never appeared", $time, fwd_q[0].rd);
                end else begin
                    compare_value("fwd_idx", fwd_q[0].rd, fwd_idx);
                    compare_value("fwd_data", fwd_q[0].data, fwd_data);
                end
                void'(fwd_q.pop_front());
            end else if (fwd_valid) begin
                errors++;
                $display("At %0t fwd_valid was high with nothing to forward", $time);
            end
            cyc++;
        end
    end

    function automatic logic [31:0] load_value(input lsu_op_e op, input logic [5:0] addr);
        logic [5:0]  wa;
        logic [5:0]  ha;
        logic [15:0] half;
        wa   = addr & 6'h3c;
        ha   = addr & 6'h3e;  // Bit 0 is ignored for half-words
        half = {ram_model[ha + 1], ram_model[ha]};
        case (op)
            OP_LB:   return {{24{ram_model[addr][7]}}, ram_model[addr]};
            OP_LBU:  return {24'h0, ram_model[addr]};
            OP_LH:   return {{16{half[15]}}, half};
            OP_LHU:  return {16'h0, half};
            default: return {ram_model[wa + 3], ram_model[wa + 2],
                             ram_model[wa + 1], ram_model[wa]};
        endcase
    endfunction

    // A killed issue is flushed later on, so it leaves no trace in the model
    task automatic issue(input lsu_op_e op, input logic [5:0] addr, input logic [31:0] sdata,
                         input logic fl, input logic killed);
        expect_t e;
        @(negedge clk);
        in_valid      = 1'b1;
        in_op         = op;
        in_imm        = $urandom % 16;
        in_base       = {26'h0, addr} - in_imm;
        in_store_data = sdata;
        in_rd         = 5'd1 + 5'($urandom % 31);
        in_pc         = $urandom & 32'hffff_fffc;
        in_ex_out     = $urandom;
        flush         = fl;
        e.rd          = in_rd;
        e.pc          = in_pc;
        if (!killed) begin
            case (op)
                OP_SB: ram_model[addr] = sdata[7:0];
                OP_SH: begin
                    ram_model[addr & 6'h3e]       = sdata[7:0];
                    ram_model[(addr & 6'h3e) + 1] = sdata[15:8];
                end
                OP_SW: begin
                    for (int i = 0; i < 4; i++) ram_model[(addr & 6'h3c) + i] = sdata[i*8 +: 8];
                end
                default: begin
                    e.cyc  = cyc + 2;
                    e.data = (op == OP_LINK) ? in_pc + 32'd4 : in_ex_out;
                    fwd_q.push_back(e);
                    e.cyc  = cyc + 3;
                    if (op != OP_ALU && op != OP_LINK) e.data = load_value(op, addr);
                    wb_q.push_back(e);
                end
            endcase
        end
    endtask

    task automatic idle(input logic fl);
        @(negedge clk);
        in_valid = 1'b0;
        flush    = fl;
    endtask

    task automatic drain();
        idle(1'b0);
        while (wb_q.size() > 0 || fwd_q.size() > 0) idle(1'b0);
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("Test %s passed", name);
        end else begin
            $display("Test %s failed with %0d errors", name, errors - err_before);
        end
    endtask

    // ############################################################
    // Directed tests
    // ############################################################

    task automatic word_store_load();
        int         e0;
        logic [5:0] a [8];
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a[i] = 6'(($urandom % 16) * 4);
            issue(OP_SW, a[i], $urandom, 1'b0, 1'b0);
        end
        for (int i = 0; i < 8; i++) issue(OP_LW, a[i], 32'h0, 1'b0, 1'b0);
        drain();
        report("word store and load", e0);
    endtask

    task automatic sub_word_loads();
        int e0;
        e0 = errors;
        issue(OP_SW, 6'd40, 32'h80f1_7f0c, 1'b0, 1'b0);  // Both sign states in each lane
        issue(OP_SW, 6'd44, 32'h7e01_ff92, 1'b0, 1'b0);
        for (int w = 40; w <= 44; w += 4) begin
            for (int off = 0; off < 4; off++) begin
                issue(OP_LB, 6'(w + off), 32'h0, 1'b0, 1'b0);
                issue(OP_LBU, 6'(w + off), 32'h0, 1'b0, 1'b0);
                issue(OP_LH, 6'(w + off), 32'h0, 1'b0, 1'b0);
                issue(OP_LHU, 6'(w + off), 32'h0, 1'b0, 1'b0);
            end
        end
        drain();
        report("byte and half-word loads", e0);
    endtask

    task automatic partial_stores();
        int         e0;
        logic [5:0] w;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            w = 6'(($urandom % 16) * 4);
            issue(OP_SB, w + 6'(i), $urandom, 1'b0, 1'b0);
            issue(OP_LW, w, 32'h0, 1'b0, 1'b0);  // Right behind the store
            issue(OP_SH, w + 6'(i), $urandom, 1'b0, 1'b0);
            issue(OP_LW, w, 32'h0, 1'b0, 1'b0);
        end
        drain();
        report("partial stores", e0);
    endtask

    task automatic mixed_stream();
        int e0;
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            issue(lsu_op_e'($urandom % 10), 6'($urandom % 64), $urandom, 1'b0, 1'b0);
        end
        drain();
        report("mixed stream", e0);
    endtask

    task automatic forward_timing();
        int e0;
        e0 = errors;
        issue(OP_ALU, 6'd0, 32'h0, 1'b0, 1'b0);
        issue(OP_LINK, 6'd0, 32'h0, 1'b0, 1'b0);
        issue(OP_LW, 6'd8, 32'h0, 1'b0, 1'b0);
        issue(OP_SW, 6'd60, $urandom, 1'b0, 1'b0);  // No forward from a store
        issue(OP_LINK, 6'd0, 32'h0, 1'b0, 1'b0);
        issue(OP_ALU, 6'd0, 32'h0, 1'b0, 1'b0);
        issue(OP_LBU, 6'd13, 32'h0, 1'b0, 1'b0);
        issue(OP_LINK, 6'd0, 32'h0, 1'b0, 1'b0);
        drain();
        report("forwarding", e0);
    endtask

    // Flush in cycle c drops the issues of c-1 and c-2 but keeps the one of c
    task automatic flush_kill();
        int e0;
        e0 = errors;
        idle(1'b0);
        issue(OP_SW, 6'd20, 32'hdead_beef, 1'b0, 1'b1);
        issue(OP_LW, 6'd20, 32'h0, 1'b1, 1'b0);
        idle(1'b0);
        issue(OP_SB, 6'd21, 32'h5a, 1'b0, 1'b1);
        issue(OP_LW, 6'd20, 32'h0, 1'b1, 1'b0);
        issue(OP_ALU, 6'd0, 32'h0, 1'b0, 1'b1);  // Flushed two cycles later
        issue(OP_LH, 6'd22, 32'h0, 1'b0, 1'b1);
        issue(OP_LINK, 6'd0, 32'h0, 1'b1, 1'b0);
        drain();
        report("flush", e0);
    endtask

    initial begin
        void'($urandom(32'h846eefc9));
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        flush         = 1'b0;
        in_op         = OP_ALU;
        in_base       = '0;
        in_imm        = '0;
        in_store_data = '0;
        in_rd         = '0;
        in_pc         = '0;
        in_ex_out     = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int w = 0; w < 16; w++) begin
            issue(OP_SW, 6'(w * 4), 32'h9e37_79b9 * (w * 4 + 1), 1'b0, 1'b0);
        end
        word_store_load();
        sub_word_loads();
        partial_stores();
        mixed_stream();
        forward_timing();
        flush_kill();
        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(ISSUE_COUNT * 10 + 1000);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_top.f */
+incdir+design
design/lsu_pkg.sv
design/dcache_if.sv
design/lsu_ctrl.sv
design/agu_stage.sv
design/data_ram.sv
design/load_align_stage.sv
design/lsu_top.sv
test/lsu_tb.sv
